// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

    ////////////////////
    // Instruction word
    ////////////////////

    typedef logic [31:0] instr_t;

    ////////////////////
    // Opcode classes
    ////////////////////

    // Encoded on opcode bits 6..2, anything not listed is unknown
    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,
        OP_IMM    = 5'b00100,
        OP_AUIPC  = 5'b00101,
        OP_STORE  = 5'b01000,
        OP_R      = 5'b01100,
        OP_LUI    = 5'b01101,
        OP_BRANCH = 5'b11000,
        OP_JALR   = 5'b11001,
        OP_JAL    = 5'b11011
    } opclass_e;

    ////////////////////
    // Field layout
    ////////////////////

    // R-type view, other formats reuse the same bit positions
    typedef struct packed {
        logic [6:0] funct7;  // Bits 31..25
        logic [4:0] rs2;     // Bits 24..20
        logic [4:0] rs1;     // Bits 19..15
        logic [2:0] funct3;  // Bits 14..12
        logic [4:0] rd;      // Bits 11..7
        logic [6:0] opcode;  // Bits 6..0
    } inst_fields_t;

endpackage

// ==== design/seg_disp_pkg.sv ====
package seg_disp_pkg;

    ////////////////////
    // Display types
    ////////////////////

    localparam int NUM_DIGITS = 8;

    typedef logic [7:0] char_t;  // ASCII
    typedef logic [6:0] seg_t;   // Active low, gfedcba

    typedef struct packed {
        seg_t digit7;  // Leftmost
        seg_t digit6;
        seg_t digit5;
        seg_t digit4;
        seg_t digit3;
        seg_t digit2;
        seg_t digit1;
        seg_t digit0;
    } disp_t;

    typedef struct packed {
        logic            known;
        char_t [3:0]     chars;  // chars[3] is the first letter
    } mnem_t;

    typedef struct packed {
        logic [3:0] op_hi;
        logic [3:0] op_mid;
        logic [3:0] op_lo;
    } operand_t;

    ////////////////////
    // Glyph helpers
    ////////////////////

    function automatic seg_t char_to_seg(input char_t c);
        case (c)
            "0", "O": return 7'b1000000;
            "1", "I": return 7'b1111001;
            "2":      return 7'b0100100;
            "3":      return 7'b0110000;
            "4":      return 7'b0011001;
            "5", "S": return 7'b0010010;
            "6":      return 7'b0000010;
            "7":      return 7'b1111000;
            "8":      return 7'b0000000;
            "9", "G": return 7'b0010000;
            "A":      return 7'b0001000;
            "B":      return 7'b0000011;  // Lower case
            "C":      return 7'b1000110;
            "D":      return 7'b0100001;  // Lower case
            "E":      return 7'b0000110;
            "F":      return 7'b0001110;
            "H":      return 7'b0001001;
            "J":      return 7'b1100001;
            "L":      return 7'b1000111;
            "P":      return 7'b0001100;
            "Q":      return 7'b0011000;  // Lower case
            "R":      return 7'b0101111;  // Lower case
            "T":      return 7'b0000111;  // Lower case
            "U":      return 7'b1000001;
            "Y":      return 7'b0010001;
            default:  return 7'b1111111;  // Blank
        endcase
    endfunction

    function automatic char_t hex_to_char(input logic [3:0] nib);
        if (nib <= 4'h9) begin
            return "0" + char_t'(nib);
        end
        return "A" + char_t'(nib - 4'hA);
    endfunction

endpackage

// ==== design/disp_input_stage.sv ====
`timescale 1ns/1ps

module disp_input_stage #(
    parameter int CREDITS = 2
) (
    input  logic               clk,
    input  logic               arst_n,
    input  rv_isa_pkg::instr_t instr,
    input  logic               in_valid,
    output logic               in_ready,
    input  logic               out_credit,
    output rv_isa_pkg::instr_t instr_q,
    output logic               instr_vld
);

    localparam int CW = $clog2(CREDITS + 1);

    logic [CW-1:0] credit_cnt;
    logic          accept;

    assign in_ready = (credit_cnt != '0);  // Registered count only
    assign accept   = in_valid && in_ready;

    ////////////////////
    // Credit counter
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= CW'(CREDITS);
        end else begin
            case ({accept, out_credit})
                2'b10:   credit_cnt <= credit_cnt - CW'(1);
                2'b01:   credit_cnt <= credit_cnt + CW'(1);
                default: credit_cnt <= credit_cnt;  // Both or neither
            endcase
        end
    end

    ////////////////////
    // Instruction register
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_vld <= 1'b0;
        end else begin
            instr_vld <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
        end
    end

    // Sink may never hold more words than it was granted
    a_cnt_max: assert property (@(posedge clk) disable iff (!arst_n)
        credit_cnt <= CW'(CREDITS));
    a_no_extra_credit: assert property (@(posedge clk) disable iff (!arst_n)
        out_credit |-> (credit_cnt != CW'(CREDITS)));
    // Stalled offer leaves the pipe untouched
    a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (in_valid && !in_ready) |=> ($stable(instr_q) && !instr_vld));

endmodule

// ==== design/mnemonic_decoder.sv ====
`timescale 1ns/1ps

module mnemonic_decoder (
    input  rv_isa_pkg::instr_t    instr_q,
    output seg_disp_pkg::mnem_t   mnem
);

    rv_isa_pkg::inst_fields_t fields;
    rv_isa_pkg::opclass_e     opclass;

    assign fields  = rv_isa_pkg::inst_fields_t'(instr_q);
    assign opclass = rv_isa_pkg::opclass_e'(fields.opcode[6:2]);

    always_comb begin
        mnem.known = 1'b1;
        mnem.chars = "    ";
        case (opclass)
            rv_isa_pkg::OP_R: begin
                case ({fields.funct7[5], fields.funct3})  // Only funct7 bit 5 matters
                    4'b0_000: mnem.chars = "ADD ";
                    4'b1_000: mnem.chars = "SUB ";
                    4'b0_111: mnem.chars = "AND ";
                    4'b0_110: mnem.chars = "OR  ";
                    4'b0_100: mnem.chars = "XOR ";
                    4'b0_001: mnem.chars = "SLL ";
                    4'b0_101: mnem.chars = "SRL ";
                    4'b1_101: mnem.chars = "SRA ";
                    4'b0_010: mnem.chars = "SLT ";
                    4'b0_011: mnem.chars = "SLTU";
                    default:  mnem.known = 1'b0;
                endcase
            end
            rv_isa_pkg::OP_IMM: begin
                case (fields.funct3)
                    3'b000:  mnem.chars = "ADDI";
                    3'b111:  mnem.chars = "ANDI";
                    3'b110:  mnem.chars = "ORI ";
                    3'b100:  mnem.chars = "XORI";
                    3'b010:  mnem.chars = "SLTI";
                    3'b011:  mnem.chars = "SLIU";  // Shortened SLTIU
                    default: mnem.known = 1'b0;    // Shifts not shown
                endcase
            end
            rv_isa_pkg::OP_LOAD: begin
                case (fields.funct3)
                    3'b010:  mnem.chars = "LW  ";
                    3'b001:  mnem.chars = "LH  ";
                    3'b000:  mnem.chars = "LB  ";
                    3'b101:  mnem.chars = "LHU ";
                    3'b100:  mnem.chars = "LBU ";
                    default: mnem.known = 1'b0;
                endcase
            end
            rv_isa_pkg::OP_STORE: begin
                case (fields.funct3)
                    3'b010:  mnem.chars = "SW  ";
                    3'b001:  mnem.chars = "SH  ";
                    3'b000:  mnem.chars = "SB  ";
                    default: mnem.known = 1'b0;
                endcase
            end
            rv_isa_pkg::OP_BRANCH: begin
                case (fields.funct3)
                    3'b000:  mnem.chars = "BEQ ";
                    3'b001:  mnem.chars = "BNE ";
                    3'b100:  mnem.chars = "BLT ";
                    3'b101:  mnem.chars = "BGE ";
                    3'b110:  mnem.chars = "BLTU";
                    3'b111:  mnem.chars = "BGEU";
                    default: mnem.known = 1'b0;
                endcase
            end
            rv_isa_pkg::OP_JAL:   mnem.chars = "JAL ";
            rv_isa_pkg::OP_JALR:  mnem.chars = "JALR";
            rv_isa_pkg::OP_LUI:   mnem.chars = "LUI ";
            rv_isa_pkg::OP_AUIPC: mnem.chars = "AUIP";  // Shortened AUIPC
            default:              mnem.known = 1'b0;
        endcase
    end

endmodule

// ==== design/operand_extractor.sv ====
`timescale 1ns/1ps

module operand_extractor (
    input  rv_isa_pkg::instr_t       instr_q,
    output seg_disp_pkg::operand_t   operands
);

    rv_isa_pkg::inst_fields_t fields;
    rv_isa_pkg::opclass_e     opclass;

    assign fields  = rv_isa_pkg::inst_fields_t'(instr_q);
    assign opclass = rv_isa_pkg::opclass_e'(fields.opcode[6:2]);

    // Layout is op_hi, op_mid, op_lo
    always_comb begin
        case (opclass)
            rv_isa_pkg::OP_R: begin
                operands = '{fields.rs1[3:0], fields.rs2[3:0], fields.rd[3:0]};
            end
            rv_isa_pkg::OP_IMM,
            rv_isa_pkg::OP_LOAD,
            rv_isa_pkg::OP_JALR: begin
                operands = '{fields.rs1[3:0], instr_q[23:20], fields.rd[3:0]};  // imm[3:0]
            end
            rv_isa_pkg::OP_STORE: begin
                operands = '{fields.rs1[3:0], instr_q[27:24], fields.rs2[3:0]};
            end
            rv_isa_pkg::OP_BRANCH: begin
                operands = '{fields.rs1[3:0], fields.rs2[3:0], instr_q[11:8]};
            end
            rv_isa_pkg::OP_JAL: begin
                operands = '{fields.rd[3:0], instr_q[23:20], instr_q[19:16]};
            end
            rv_isa_pkg::OP_LUI,
            rv_isa_pkg::OP_AUIPC: begin
                operands = '{instr_q[31:28], instr_q[27:24], fields.rd[3:0]};  // Upper imm
            end
            default: begin
                operands = '0;  // Shown as raw hex anyway
            end
        endcase
    end

endmodule

// ==== design/display_composer.sv ====
`timescale 1ns/1ps

module display_composer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rv_isa_pkg::instr_t     instr_q,
    input  logic                   instr_vld,
    input  seg_disp_pkg::mnem_t    mnem,
    input  seg_disp_pkg::operand_t operands,
    output seg_disp_pkg::disp_t    disp,
    output logic                   out_valid
);

    seg_disp_pkg::char_t [seg_disp_pkg::NUM_DIGITS-1:0] chars;
    seg_disp_pkg::seg_t  [seg_disp_pkg::NUM_DIGITS-1:0] segs;

    ////////////////////
    // Character select
    ////////////////////

    always_comb begin
        if (mnem.known) begin
            chars[7:4] = mnem.chars;
            chars[3]   = seg_disp_pkg::hex_to_char(operands.op_hi);
            chars[2]   = seg_disp_pkg::hex_to_char(operands.op_mid);
            chars[1]   = seg_disp_pkg::hex_to_char(operands.op_lo);
            chars[0]   = " ";
        end else begin
            for (int i = 0; i < seg_disp_pkg::NUM_DIGITS; i++) begin
                chars[i] = seg_disp_pkg::hex_to_char(instr_q[4*i +: 4]);  // Raw word
            end
        end
        for (int i = 0; i < seg_disp_pkg::NUM_DIGITS; i++) begin
            segs[i] = seg_disp_pkg::char_to_seg(chars[i]);
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= instr_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_vld) begin
            disp <= seg_disp_pkg::disp_t'(segs);  // Holds last word between updates
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(out_valid));

endmodule

// ==== design/inst_display_top.sv ====
`timescale 1ns/1ps

module inst_display_top #(
    parameter int CREDITS = 2
) (
    input  logic                clk,
    input  logic                arst_n,
    input  rv_isa_pkg::instr_t  instr,
    input  logic                in_valid,
    output logic                in_ready,
    output seg_disp_pkg::disp_t disp,
    output logic                out_valid,
    input  logic                out_credit
);

    rv_isa_pkg::instr_t     instr_q;
    logic                   instr_vld;
    seg_disp_pkg::mnem_t    mnem;
    seg_disp_pkg::operand_t operands;

    disp_input_stage #(
        .CREDITS (CREDITS)
    ) i_input_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr      (instr),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_credit (out_credit),
        .instr_q    (instr_q),
        .instr_vld  (instr_vld)
    );

    // Decoder and extractor work side by side on the same word
    mnemonic_decoder i_mnem_dec (
        .instr_q (instr_q),
        .mnem    (mnem)
    );

    operand_extractor i_opnd_ext (
        .instr_q  (instr_q),
        .operands (operands)
    );

    display_composer i_composer (
        .clk       (clk),
        .arst_n    (arst_n),
        .instr_q   (instr_q),
        .instr_vld (instr_vld),
        .mnem      (mnem),
        .operands  (operands),
        .disp      (disp),
        .out_valid (out_valid)
    );

endmodule

// ==== verif/disp_checker.sv ====
`timescale 1ns/1ps

module disp_checker #(
    parameter int CREDITS = 2
) (
    input  logic                clk,
    input  logic                arst_n,
    input  rv_isa_pkg::instr_t  instr,
    input  logic                in_valid,
    input  logic                in_ready,
    input  seg_disp_pkg::disp_t disp,
    input  logic                out_valid,
    input  logic                out_credit,
    output int                  pending,
    output int                  data_errs,
    output int                  flow_errs
);

    seg_disp_pkg::disp_t exp_q[$];
    int unsigned         due_q[$];  // Cycle each word must show up
    int unsigned         cyc = 0;
    int                  credits = CREDITS;
    int                  held = 0;  // Words at the sink with credit not yet back

    ////////////////////
    // Reference model
    ////////////////////

    // Lit segments in gfedcba order with B D Q R T in lower case
    function automatic seg_disp_pkg::seg_t glyph(input byte c);
        string      keys;
        logic [6:0] lit [25];
        byte        k;
        keys = "0123456789ABCDEFHJLPQRTUY";
        lit  = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07, 7'h7F, 7'h6F,
                 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71, 7'h76, 7'h1E, 7'h38, 7'h73,
                 7'h67, 7'h50, 7'h78, 7'h3E, 7'h6E};
        case (c)
            "G":     k = "9";
            "I":     k = "1";
            "O":     k = "0";
            "S":     k = "5";
            default: k = c;
        endcase
        for (int i = 0; i < 25; i++) begin
            if (keys[i] == k) begin
                return ~lit[i];
            end
        end
        return 7'h7F;  // Blank
    endfunction

    // Four-letter name or ???? when not decoded
    function automatic string mnem_name(input logic [31:0] w);
        string tbl;
        int    pos;
        pos = 4 * int'(w[14:12]);
        case (w[6:2])
            5'b01100: tbl = w[30] ? "SUB ????????????????SRA ????????"
                                  : "ADD SLL SLT SLTUXOR SRL OR  AND ";
            5'b00100: tbl = "ADDI????SLTISLIUXORI????ORI ANDI";
            5'b00000: tbl = "LB  LH  LW  ????LBU LHU ????????";
            5'b01000: tbl = "SB  SH  SW  ????????????????????";
            5'b11000: tbl = "BEQ BNE ????????BLT BGE BLTUBGEU";
            5'b11011: return "JAL ";
            5'b11001: return "JALR";
            5'b01101: return "LUI ";
            5'b00101: return "AUIP";
            default:  return "????";
        endcase
        return tbl.substr(pos, pos + 3);
    endfunction

    function automatic seg_disp_pkg::disp_t expected_disp(input logic [31:0] w);
        string       name;
        string       txt;
        logic [11:0] opnd;
        logic [55:0] segs;
        name = mnem_name(w);
        case (w[6:2])
            5'b01100, 5'b00100, 5'b00000, 5'b11001: opnd = {w[18:15], w[23:20], w[10:7]};
            5'b01000: opnd = {w[18:15], w[27:24], w[23:20]};
            5'b11000: opnd = {w[18:15], w[23:20], w[11:8]};
            5'b11011: opnd = {w[10:7], w[23:20], w[19:16]};
            default:  opnd = {w[31:28], w[27:24], w[10:7]};  // LUI, AUIPC
        endcase
        if (name == "????") begin
            txt = $sformatf("%08h", w);
        end else begin
            txt = $sformatf("%s%03h ", name, opnd);
        end
        txt = txt.toupper();
        for (int i = 0; i < 8; i++) begin
            segs[55 - 7*i -: 7] = glyph(txt[i]);  // First char on digit 7
        end
        return seg_disp_pkg::disp_t'(segs);
    endfunction

    ////////////////////
    // Monitor
    ////////////////////

    // Sampled mid-cycle away from the clock edge
    always @(negedge clk) begin
        if (!arst_n) begin
            exp_q.delete();
            due_q.delete();
            credits = CREDITS;
            held    = 0;
            if (out_valid !== 1'b0) begin
                $display("[FAIL] out_valid: got %h, expected %h", out_valid, 1'b0);
                flow_errs++;
            end
            if (in_ready !== 1'b1) begin
                $display("[FAIL] in_ready: got %h, expected %h", in_ready, 1'b1);
                flow_errs++;
            end
        end else begin
            if (in_ready !== (credits != 0)) begin
                $display("[FAIL] in_ready: got %h, expected %h", in_ready, credits != 0);
                flow_errs++;
            end
            if (out_valid === 1'b1) begin
                held++;
                if (exp_q.size() == 0) begin
                    $display("Output word appeared with no instruction in flight");
                    flow_errs++;
                end else begin
                    if (due_q[0] != cyc) begin
                        $display("Word out in cycle %0d, due in cycle %0d", cyc, due_q[0]);
                        flow_errs++;
                    end
                    if (disp !== exp_q[0]) begin
                        $display("[FAIL] disp: got %h, expected %h", disp, exp_q[0]);
                        data_errs++;
                    end
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                end
            end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
                $display("Output word missing in cycle %0d", cyc);
                flow_errs++;
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
            if (out_credit) begin
                held--;
            end
            if (held < 0 || held > CREDITS) begin
                $display("Sink holds %0d words, outside 0 to %0d", held, CREDITS);
                flow_errs++;
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_disp(instr));
                due_q.push_back(cyc + 2);
            end
            credits = credits - int'(in_valid && in_ready) + int'(out_credit);
        end
        cyc++;
        pending = exp_q.size();
    end

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int CREDITS        = 2;
    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 9 + 100;

    logic                clk;
    logic                arst_n;
    rv_isa_pkg::instr_t  instr;
    logic                in_valid;
    logic                in_ready;
    seg_disp_pkg::disp_t disp;
    logic                out_valid;
    logic                out_credit = 1'b0;
    int                  pending;
    int                  data_errs;
    int                  flow_errs;
    int unsigned         cyc = 0;
    int unsigned         credit_due[$];  // Cycles in which the sink hands a credit back
    logic [31:0]         rng_state = 32'd76;

    // R, OP-IMM, LOAD, STORE, BRANCH, JAL, JALR, LUI, AUIPC
    logic [6:0] known_ops [9] = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h63,
                                  7'h6F, 7'h67, 7'h37, 7'h17};

    inst_display_top #(.CREDITS(CREDITS)) i_dut (.*);

    disp_checker #(.CREDITS(CREDITS)) i_checker (.*);

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // One of nine decoded classes, or one time in ten a random opcode
    function logic [31:0] make_instr();
        logic [31:0] w;
        logic [3:0]  pick;
        w    = next_rand();
        pick = 4'(next_rand() % 10);
        if (pick < 4'd9) begin
            w[6:0] = known_ops[pick];
        end
        return w;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////
    // Sink model
    ////////////////////

    always @(negedge clk) begin
        int unsigned due;
        if (!arst_n) begin
            credit_due.delete();
        end else if (out_valid) begin
            due = cyc + 1 + next_rand() % 6;
            if (credit_due.size() != 0 && credit_due[$] > due) begin
                due = credit_due[$];  // Credits go back in order
            end
            credit_due.push_back(due);
        end
    end

    always @(posedge clk) begin
        #2;
        if (arst_n && credit_due.size() != 0 && credit_due[0] <= cyc) begin
            out_credit = 1'b1;
            void'(credit_due.pop_front());
        end else begin
            out_credit = 1'b0;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        logic took;
        instr    = '0;
        in_valid = 1'b0;
        arst_n   = 1'b0;
        repeat (3) @(posedge clk);
        #2 arst_n = 1'b1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            if (n == NUM_INSTR / 2) begin
                arst_n = 1'b0;  // Mid-run reset drops words in flight
                repeat (3) @(posedge clk);
                #2 arst_n = 1'b1;
            end
            while (next_rand() % 3 == 0) begin
                @(posedge clk);
                #2;
            end
            instr    = make_instr();
            in_valid = 1'b1;
            took     = 1'b0;
            while (!took) begin
                @(negedge clk);
                took = in_ready;
                @(posedge clk);
                #2;
            end
            in_valid = 1'b0;
        end
        while (pending != 0 || credit_due.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("Done: %0d instructions, %0d data errors, %0d flow errors",
                 NUM_INSTR, data_errs, flow_errs);
        if (data_errs == 0 && flow_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
design/rv_isa_pkg.sv
design/seg_disp_pkg.sv
design/disp_input_stage.sv
design/mnemonic_decoder.sv
design/operand_extractor.sv
design/display_composer.sv
design/inst_display_top.sv
verif/disp_checker.sv
verif/tb_top.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_top
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)" && exit 1)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
